/* periph_pkg.sv */
// Shared types and register map of the robot-board peripheral block
// All accesses are full 32-bit words, byte lanes are not decoded
// Address bits 7:6 pick the bank and bits 4:2 the register
// Bank widths must not exceed the 32-bit data word

package periph_pkg;

   // **************************************************
   // Bus types
   // **************************************************

   typedef logic [15:0] bus_addr_t;
   typedef logic [31:0] bus_data_t;

   // Register index inside one bank
   typedef logic [2:0]  reg_idx_t;

   // Bank number, bank 3 is unmapped
   typedef logic [1:0]  bank_idx_t;

   // One request as captured from the slave port
   typedef struct packed {
      bus_addr_t adr;
      bus_data_t wdata;
      logic      we;
   } bus_req_t;

   // One-cycle access toward a single bank
   typedef struct packed {
      logic      rd;
      logic      wr;
      reg_idx_t  idx;
      bus_data_t wdata;
   } bank_access_t;

   // Request decoder FSM
   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,
      ST_ACCESS = 2'd1,
      ST_RESP   = 2'd2
   } dec_state_t;

   // **************************************************
   // Register map
   // **************************************************

   // Address fields
   localparam int ADR_IDX_LSB  = 2;
   localparam int ADR_BANK_LSB = 6;

   // REG_IN is read only, REG_EVENT is write one to clear
   localparam reg_idx_t REG_IN    = 3'd0;
   localparam reg_idx_t REG_OUT   = 3'd1;
   localparam reg_idx_t REG_OE    = 3'd2;
   localparam reg_idx_t REG_IE    = 3'd3;
   localparam reg_idx_t REG_EVENT = 3'd4;

   localparam bank_idx_t BANK_PINS = 2'd0;
   localparam bank_idx_t BANK_BTN  = 2'd1;
   localparam bank_idx_t BANK_BOT  = 2'd2;

   localparam int NUM_BANKS = 3;

endpackage

/* btn_debounce.sv */
// Push-button filter, one counter per button
// A new level shows after 2 sync cycles, DEBOUNCE_CYCLES stable cycles
// and one more cycle; shorter pulses are dropped
// DEBOUNCE_CYCLES must be at least 1
`timescale 1ns/1ps

module btn_debounce #(
   parameter int WIDTH           = 5,
   parameter int DEBOUNCE_CYCLES = 16
) (
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic [WIDTH-1:0] i_btn,
   output logic [WIDTH-1:0] o_btn_db
);

   localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);
   localparam logic [CW-1:0] CNT_MAX = CW'(DEBOUNCE_CYCLES);

   logic [WIDTH-1:0] btn_meta;
   logic [WIDTH-1:0] btn_sync;
   logic [WIDTH-1:0] btn_db_q;
   logic [CW-1:0]    cnt_q [WIDTH];

   // Two-flop synchronizer
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         btn_meta <= '0;
         btn_sync <= '0;
      end else begin
         btn_meta <= i_btn;
         btn_sync <= btn_meta;
      end
   end

   // Count while the synced level differs from the filtered one
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         btn_db_q <= '0;
         for (int i = 0; i < WIDTH; i++) begin
            cnt_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < WIDTH; i++) begin
            if (btn_sync[i] == btn_db_q[i]) begin
               cnt_q[i] <= '0;
            end else if (cnt_q[i] == CNT_MAX) begin
               // Difference held long enough
               btn_db_q[i] <= btn_sync[i];
               cnt_q[i]    <= '0;
            end else begin
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

   assign o_btn_db = btn_db_q;

endmodule

/* wb_req_decode.sv */
// Slave port request decoder, one request in flight
// The master holds cyc, stb and data until it sees ack
// Bank strobes last exactly one cycle; bank 3 gets none but is acknowledged
`timescale 1ns/1ps

module wb_req_decode
   import periph_pkg::*;
(
   input  logic                          clk,
   input  logic                          i_rst_n,
   input  logic                          i_wb_cyc,
   input  logic                          i_wb_stb,
   input  logic                          i_wb_we,
   input  bus_addr_t                     i_wb_adr,
   input  bus_data_t                     i_wb_dat,
   output bank_access_t [NUM_BANKS-1:0]  o_access,
   output logic                          o_rsp_valid,
   output bank_idx_t                     o_rsp_bank
);

   dec_state_t             state_q;
   bus_req_t               req_q;
   bank_idx_t              req_bank;
   logic                   req_start;
   logic [NUM_BANKS-1:0]   bank_stb;
   logic [2*NUM_BANKS-1:0] acc_stb;

   assign req_start = (state_q == ST_IDLE) && i_wb_cyc && i_wb_stb;
   assign req_bank  = req_q.adr[ADR_BANK_LSB +: $bits(bank_idx_t)];

   // Fixed walk from IDLE through ACCESS and RESP back to IDLE
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE:   state_q <= req_start ? ST_ACCESS : ST_IDLE;
            ST_ACCESS: state_q <= ST_RESP;
            default:   state_q <= ST_IDLE;
         endcase
      end
   end

   // Request payload
   always_ff @(posedge clk) begin
      if (req_start) begin
         req_q <= '{adr: i_wb_adr, wdata: i_wb_dat, we: i_wb_we};
      end
   end

   // Strobe only toward the addressed bank
   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         bank_stb[b]       = (state_q == ST_ACCESS) && (req_bank == bank_idx_t'(b));
         o_access[b].rd    = bank_stb[b] && !req_q.we;
         o_access[b].wr    = bank_stb[b] && req_q.we;
         o_access[b].idx   = req_q.adr[ADR_IDX_LSB +: $bits(reg_idx_t)];
         o_access[b].wdata = req_q.wdata;
         acc_stb[2*b]      = o_access[b].rd;
         acc_stb[2*b+1]    = o_access[b].wr;
      end
   end

   assign o_rsp_valid = (state_q == ST_ACCESS);
   assign o_rsp_bank  = req_bank;

   // At most one read or write strobe toward all banks together
   a_one_bank: assert property (@(posedge clk) disable iff (!i_rst_n)
      $onehot0(acc_stb));

endmodule

/* gpio_bank.sv */
// GPIO register bank with IN, OUT, OE, IE and EVENT registers
// Inputs pass two sync flops; a rising edge sets EVENT one cycle later
// o_irq follows the enabled events with one more cycle of delay
// WIDTH is at most 32, upper bits read zero
`timescale 1ns/1ps

module gpio_bank
   import periph_pkg::*;
#(
   parameter int WIDTH = 32
) (
   input  logic             clk,
   input  logic             i_rst_n,
   input  bank_access_t     i_access,
   input  logic [WIDTH-1:0] i_pin_in,
   output logic [WIDTH-1:0] o_pin_out,
   output logic [WIDTH-1:0] o_pin_oe,
   output bus_data_t        o_rdata,
   output logic             o_irq
);

   logic [WIDTH-1:0] in_meta;
   logic [WIDTH-1:0] in_sync;
   logic [WIDTH-1:0] in_last;
   logic [WIDTH-1:0] rise;
   logic [WIDTH-1:0] out_q;
   logic [WIDTH-1:0] oe_q;
   logic [WIDTH-1:0] ie_q;
   logic [WIDTH-1:0] event_q;
   logic [WIDTH-1:0] wr_val;
   logic [WIDTH-1:0] ev_clr;
   logic             irq_q;
   bus_data_t        rd_word;

   // **************************************************
   // Input synchronizer and edge detect
   // **************************************************

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         in_meta <= '0;
         in_sync <= '0;
         in_last <= '0;
      end else begin
         in_meta <= i_pin_in;
         in_sync <= in_meta;
         in_last <= in_sync;
      end
   end

   assign rise = in_sync & ~in_last;

   // **************************************************
   // Control registers
   // **************************************************

   assign wr_val = i_access.wdata[WIDTH-1:0];
   assign ev_clr = (i_access.wr && i_access.idx == REG_EVENT) ? wr_val : '0;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         out_q <= '0;
         oe_q  <= '0;
         ie_q  <= '0;
      end else if (i_access.wr) begin
         case (i_access.idx)
            REG_OUT: out_q <= wr_val;
            REG_OE:  oe_q  <= wr_val;
            REG_IE:  ie_q  <= wr_val;
            default: ;
         endcase
      end
   end

   // Set wins over a clear in the same cycle
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         event_q <= '0;
         irq_q   <= 1'b0;
      end else begin
         event_q <= (event_q & ~ev_clr) | rise;
         irq_q   <= |(event_q & ie_q);
      end
   end

   // Read word, zero outside a read strobe
   always_comb begin
      rd_word = '0;
      case (i_access.idx)
         REG_IN:    rd_word[WIDTH-1:0] = in_sync;
         REG_OUT:   rd_word[WIDTH-1:0] = out_q;
         REG_OE:    rd_word[WIDTH-1:0] = oe_q;
         REG_IE:    rd_word[WIDTH-1:0] = ie_q;
         REG_EVENT: rd_word[WIDTH-1:0] = event_q;
         default:   ;
      endcase
   end

   assign o_rdata   = i_access.rd ? rd_word : '0;
   assign o_pin_out = out_q;
   assign o_pin_oe  = oe_q;
   assign o_irq     = irq_q;

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_access.rd && i_access.wr));

endmodule

/* wb_resp_mux.sv */
// Response path of the slave port
// Ack and read data are registered together one cycle after rsp_valid
// Unmapped bank 3 returns zero
`timescale 1ns/1ps

module wb_resp_mux
   import periph_pkg::*;
(
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_rsp_valid,
   input  bank_idx_t                  i_rsp_bank,
   input  bus_data_t [NUM_BANKS-1:0]  i_bank_rdata,
   output logic                       o_wb_ack,
   output bus_data_t                  o_wb_rdat
);

   logic      ack_q;
   bus_data_t rdat_q;
   bus_data_t sel_word;

   // Bank select
   always_comb begin
      if (int'(i_rsp_bank) < NUM_BANKS) begin
         sel_word = i_bank_rdata[i_rsp_bank];
      end else begin
         sel_word = '0;
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= i_rsp_valid;
      end
   end

   // Read data captured with the ack
   always_ff @(posedge clk) begin
      if (i_rsp_valid) begin
         rdat_q <= sel_word;
      end
   end

   assign o_wb_ack  = ack_q;
   assign o_wb_rdat = rdat_q;

   // One request in flight, so no back-to-back acks
   a_ack_single: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_wb_ack |=> !o_wb_ack);

endmodule

/* periph_top.sv */
// Robot-board peripheral block on a word-wide Wishbone-style slave port
// Ack comes 2 cycles after the request is sampled, no stalls
// Pins leave as separate out, enable and in vectors, pads are external
// Robot bank OUT bits 7:0 drive control, bits 15:8 drive configuration
`timescale 1ns/1ps

module periph_top
   import periph_pkg::*;
#(
   parameter int DEBOUNCE_CYCLES = 16
) (
   input  logic                 clk,
   input  logic                 i_rst_n,
   // Slave port
   input  logic                 i_wb_cyc,
   input  logic                 i_wb_stb,
   input  logic                 i_wb_we,
   input  bus_addr_t            i_wb_adr,
   input  bus_data_t            i_wb_dat,
   output logic                 o_wb_ack,
   output bus_data_t            o_wb_rdat,
   // Board pins
   input  logic [31:0]          i_pin_in,
   output logic [31:0]          o_pin_out,
   output logic [31:0]          o_pin_oe,
   // Buttons and robot link
   input  logic [4:0]           i_btn,
   input  logic [31:0]          i_bot_info,
   output logic [7:0]           o_bot_ctrl,
   output logic [7:0]           o_bot_config,
   output logic [NUM_BANKS-1:0] o_irq
);

   localparam int PIN_WIDTH = 32;
   localparam int BTN_WIDTH = 5;
   localparam int BOT_WIDTH = 32;

   bank_access_t [NUM_BANKS-1:0] access;
   bus_data_t    [NUM_BANKS-1:0] bank_rdata;
   logic                         rsp_valid;
   bank_idx_t                    rsp_bank;
   logic [BTN_WIDTH-1:0]         btn_db;
   logic [BOT_WIDTH-1:0]         bot_out;

   // **************************************************
   // Input side
   // **************************************************

   wb_req_decode u_decode (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_wb_cyc    (i_wb_cyc),
      .i_wb_stb    (i_wb_stb),
      .i_wb_we     (i_wb_we),
      .i_wb_adr    (i_wb_adr),
      .i_wb_dat    (i_wb_dat),
      .o_access    (access),
      .o_rsp_valid (rsp_valid),
      .o_rsp_bank  (rsp_bank)
   );

   btn_debounce #(
      .WIDTH           (BTN_WIDTH),
      .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
   ) u_btn_db (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_btn    (i_btn),
      .o_btn_db (btn_db)
   );

   // **************************************************
   // GPIO banks
   // **************************************************

   gpio_bank #(.WIDTH(PIN_WIDTH)) u_bank_pins (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_access  (access[BANK_PINS]),
      .i_pin_in  (i_pin_in),
      .o_pin_out (o_pin_out),
      .o_pin_oe  (o_pin_oe),
      .o_rdata   (bank_rdata[BANK_PINS]),
      .o_irq     (o_irq[BANK_PINS])
   );

   // Buttons are input only
   gpio_bank #(.WIDTH(BTN_WIDTH)) u_bank_btn (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_access  (access[BANK_BTN]),
      .i_pin_in  (btn_db),
      .o_pin_out (),
      .o_pin_oe  (),
      .o_rdata   (bank_rdata[BANK_BTN]),
      .o_irq     (o_irq[BANK_BTN])
   );

   gpio_bank #(.WIDTH(BOT_WIDTH)) u_bank_bot (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_access  (access[BANK_BOT]),
      .i_pin_in  (i_bot_info),
      .o_pin_out (bot_out),
      .o_pin_oe  (),
      .o_rdata   (bank_rdata[BANK_BOT]),
      .o_irq     (o_irq[BANK_BOT])
   );

   assign o_bot_ctrl   = bot_out[7:0];
   assign o_bot_config = bot_out[15:8];

   // **************************************************
   // Output side
   // **************************************************

   wb_resp_mux u_resp (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_rsp_valid  (rsp_valid),
      .i_rsp_bank   (rsp_bank),
      .i_bank_rdata (bank_rdata),
      .o_wb_ack     (o_wb_ack),
      .o_wb_rdat    (o_wb_rdat)
   );

endmodule

/* tb_periph_top.sv */
// Self-checking testbench for the peripheral block
// Expected read words come from a register model of the three banks
// Every bus access waits for ack, at most 4 cycles
`timescale 1ns/1ps

module tb_periph_top
   import periph_pkg::*;
();

   localparam int CLK_PERIOD  = 8;
   localparam int DB_CYCLES   = 16;
   localparam int ACK_LIMIT   = 4;
   // Test length, worst case of every access plus idle stretches
   localparam int NUM_ACCESS  = 120;
   localparam int IDLE_CYCLES = 60;
   localparam int TEST_CYCLES = NUM_ACCESS * ACK_LIMIT + IDLE_CYCLES;
   localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

   logic        clk;
   logic        rst_n;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   bus_addr_t   wb_adr;
   bus_data_t   wb_dat;
   logic        wb_ack;
   bus_data_t   wb_rdat;
   logic [31:0] pin_in;
   logic [31:0] pin_out;
   logic [31:0] pin_oe;
   logic [4:0]  btn;
   logic [31:0] bot_info;
   logic [7:0]  bot_ctrl;
   logic [7:0]  bot_config;
   logic [2:0]  irq;

   // Register model, one entry per bank
   bus_data_t model_in  [NUM_BANKS];
   bus_data_t model_out [NUM_BANKS];
   bus_data_t model_oe  [NUM_BANKS];
   bus_data_t model_ie  [NUM_BANKS];
   bus_data_t model_ev  [NUM_BANKS];

   integer    seed;
   int        errors = 0;
   int        checks = 0;
   string     name_q [$];
   bus_data_t exp_q [$];
   bus_data_t act_q [$];

   periph_top #(
      .DEBOUNCE_CYCLES (DB_CYCLES)
   ) u_dut (
      .clk          (clk),
      .i_rst_n      (rst_n),
      .i_wb_cyc     (wb_cyc),
      .i_wb_stb     (wb_stb),
      .i_wb_we      (wb_we),
      .i_wb_adr     (wb_adr),
      .i_wb_dat     (wb_dat),
      .o_wb_ack     (wb_ack),
      .o_wb_rdat    (wb_rdat),
      .i_pin_in     (pin_in),
      .o_pin_out    (pin_out),
      .o_pin_oe     (pin_oe),
      .i_btn        (btn),
      .i_bot_info   (bot_info),
      .o_bot_ctrl   (bot_ctrl),
      .o_bot_config (bot_config),
      .o_irq        (irq)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // **************************************************
   // Reference model
   // **************************************************

   function automatic bus_data_t bank_mask(input int bank);
      case (bank)
         BANK_PINS: return 32'hffff_ffff;
         BANK_BTN:  return 32'h0000_001f;
         BANK_BOT:  return 32'hffff_ffff;
         default:   return 32'h0000_0000;
      endcase
   endfunction

   function automatic bus_data_t ref_read(input int bank, input int idx);
      bus_data_t word;
      if (bank >= NUM_BANKS) begin
         return '0;
      end
      case (idx)
         REG_IN:    word = model_in[bank];
         REG_OUT:   word = model_out[bank];
         REG_OE:    word = model_oe[bank];
         REG_IE:    word = model_ie[bank];
         REG_EVENT: word = model_ev[bank];
         default:   word = '0;
      endcase
      return word & bank_mask(bank);
   endfunction

   function automatic logic [2:0] irq_ref();
      logic [2:0] v;
      for (int b = 0; b < NUM_BANKS; b++) begin
         v[b] = |(model_ev[b] & model_ie[b]);
      end
      return v;
   endfunction

   // **************************************************
   // Bus and stimulus tasks, called on a falling edge
   // **************************************************

   task automatic idle(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic expect_word(input string name, input bus_data_t exp, input bus_data_t act);
      name_q.push_back(name);
      exp_q.push_back(exp);
      act_q.push_back(act);
   endtask

   task automatic bus_access(input logic write, input int bank, input int idx,
                             input bus_data_t data, output bus_data_t rd);
      int waited;
      waited = 0;
      rd     = '0;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = write;
      wb_adr = bus_addr_t'((bank << ADR_BANK_LSB) | (idx << ADR_IDX_LSB));
      wb_dat = data;
      do begin
         @(negedge clk);
         waited++;
      end while (!wb_ack && waited < ACK_LIMIT);
      if (wb_ack) begin
         rd = wb_rdat;
      end else begin
         errors++;
         $display("ERROR: no ack within %0d cycles, bank %0d register %0d",
                  ACK_LIMIT, bank, idx);
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic bus_write(input int bank, input int idx, input bus_data_t data);
      bus_data_t unused;
      bus_access(1'b1, bank, idx, data, unused);
      if (bank < NUM_BANKS) begin
         case (idx)
            REG_OUT:   model_out[bank] = data & bank_mask(bank);
            REG_OE:    model_oe[bank]  = data & bank_mask(bank);
            REG_IE:    model_ie[bank]  = data & bank_mask(bank);
            REG_EVENT: model_ev[bank]  = model_ev[bank] & ~data;
            default:   ;
         endcase
      end
   endtask

   task automatic check_read(input string name, input int bank, input int idx);
      bus_data_t rd;
      bus_access(1'b0, bank, idx, '0, rd);
      expect_word($sformatf("%s bank %0d reg %0d", name, bank, idx), ref_read(bank, idx), rd);
   endtask

   task automatic check_bank(input string name, input int bank);
      for (int i = 0; i < 5; i++) begin
         check_read(name, bank, i);
      end
   endtask

   // New pin and robot inputs, rising bits become events
   task automatic drive_inputs(input bus_data_t pins, input bus_data_t info);
      model_ev[BANK_PINS] = model_ev[BANK_PINS] | (pins & ~pin_in);
      model_ev[BANK_BOT]  = model_ev[BANK_BOT] | (info & ~bot_info);
      model_in[BANK_PINS] = pins;
      model_in[BANK_BOT]  = info;
      pin_in   = pins;
      bot_info = info;
      idle(4);
   endtask

   // Compare process, one clock after the values were taken
   always @(posedge clk) begin : compare
      string     name;
      bus_data_t exp;
      bus_data_t act;
      while (exp_q.size() > 0) begin
         name = name_q.pop_front();
         exp  = exp_q.pop_front();
         act  = act_q.pop_front();
         checks++;
         if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("ERROR: watchdog expired after %0d ns, the run stalled", WATCHDOG_NS);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("Simulation finished: FAIL");
      $finish;
   end

   // **************************************************
   // Test sequence
   // **************************************************

   initial begin : main
      bus_data_t rd;
      time       t0;
      logic      seen;
      int        db_wait;
      seed     = 32'h0604_ee65;
      rst_n    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat   = '0;
      pin_in   = '0;
      btn      = '0;
      bot_info = '0;
      for (int b = 0; b < NUM_BANKS; b++) begin
         model_in[b]  = '0;
         model_out[b] = '0;
         model_oe[b]  = '0;
         model_ie[b]  = '0;
         model_ev[b]  = '0;
      end
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      idle(2);

      // Reset values
      for (int b = 0; b < NUM_BANKS; b++) begin
         check_bank("reset", b);
      end
      expect_word("o_irq after reset", irq_ref(), irq);
      expect_word("o_pin_oe after reset", '0, pin_oe);
      expect_word("o_bot_ctrl after reset", '0, bot_ctrl);

      // Register round trip
      for (int b = 0; b < NUM_BANKS; b++) begin
         bus_write(b, REG_OUT, $random(seed));
         bus_write(b, REG_OE, $random(seed));
         check_read("out round trip", b, REG_OUT);
         check_read("oe round trip", b, REG_OE);
      end
      expect_word("o_pin_out", model_out[BANK_PINS], pin_out);
      expect_word("o_pin_oe", model_oe[BANK_PINS], pin_oe);
      expect_word("o_bot_ctrl", model_out[BANK_BOT][7:0], bot_ctrl);
      expect_word("o_bot_config", model_out[BANK_BOT][15:8], bot_config);
      drive_inputs($random(seed), $random(seed));
      check_read("input level", BANK_PINS, REG_IN);
      check_read("input level", BANK_BOT, REG_IN);
      check_read("input events", BANK_PINS, REG_EVENT);
      check_read("input events", BANK_BOT, REG_EVENT);
      expect_word("o_irq with IE clear", irq_ref(), irq);

      // Unmapped indices and bank 3
      for (int b = 0; b < 4; b++) begin
         for (int i = 5; i < 8; i++) begin
            check_read("unmapped read", b, i);
            bus_write(b, i, $random(seed));
         end
      end
      for (int i = 0; i < 5; i++) begin
         check_read("bank 3 read", 3, i);
         bus_write(3, i, $random(seed));
      end
      for (int b = 0; b < NUM_BANKS; b++) begin
         check_bank("after unmapped writes", b);
      end

      // Short button pulse must be filtered out
      btn = 5'b00001;
      idle(DB_CYCLES / 2);
      btn = 5'b00000;
      repeat (12) check_read("short pulse", BANK_BTN, REG_IN);
      check_read("short pulse", BANK_BTN, REG_EVENT);

      // Held button level, polled until it passes the filter
      btn  = 5'b00100;
      t0   = $time;
      seen = 1'b0;
      while (!seen && ($time - t0) < 40 * CLK_PERIOD) begin
         bus_access(1'b0, BANK_BTN, REG_IN, '0, rd);
         seen = rd[2];
      end
      db_wait = ($time - t0) / CLK_PERIOD;
      if (!seen) begin
         errors++;
         $display("ERROR: held button level did not show in REG_IN within 40 cycles");
      end else if (db_wait < DB_CYCLES) begin
         errors++;
         $display("ERROR: button level passed the filter after only %0d cycles", db_wait);
      end
      model_in[BANK_BTN] = 32'h0000_0004;
      model_ev[BANK_BTN] = model_ev[BANK_BTN] | 32'h0000_0004;
      idle(2);
      check_read("held button", BANK_BTN, REG_IN);
      check_read("held button", BANK_BTN, REG_EVENT);

      // Pin event, interrupt enable and clear
      drive_inputs('0, bot_info);
      bus_write(BANK_PINS, REG_EVENT, 32'hffff_ffff);
      check_read("events cleared", BANK_PINS, REG_EVENT);
      drive_inputs(32'h0000_0020, bot_info);
      check_read("pin rising edge", BANK_PINS, REG_EVENT);
      expect_word("o_irq with IE clear", irq_ref(), irq);
      bus_write(BANK_PINS, REG_IE, 32'h0000_0020);
      idle(2);
      expect_word("o_irq with IE set", irq_ref(), irq);
      bus_write(BANK_PINS, REG_EVENT, 32'h0000_0020);
      idle(2);
      check_read("event write clear", BANK_PINS, REG_EVENT);
      expect_word("o_irq after clear", irq_ref(), irq);

      idle(2);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* compile.f */
periph_pkg.sv
btn_debounce.sv
wb_req_decode.sv
gpio_bank.sv
wb_resp_mux.sv
periph_top.sv
tb_periph_top.sv

/* Bender.yml */
package:
  name: periph_top

dependencies: {}

sources:
  - periph_pkg.sv
  - btn_debounce.sv
  - wb_req_decode.sv
  - gpio_bank.sv
  - wb_resp_mux.sv
  - periph_top.sv
  - target: test
    files:
      - tb_periph_top.sv
